//--- stopwatch_top.f
hdl/stopwatch_pkg.sv
hdl/tick_divider.sv
hdl/run_control.sv
hdl/bcd_time_counter.sv
hdl/display_sequencer.sv
hdl/spi_word_tx.sv
hdl/stopwatch_top.sv
bench/stopwatch_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= stopwatch_tb
FILELIST  ?= stopwatch_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/stopwatch_tb.sv
`default_nettype none
`timescale 1ns/1ps

module stopwatch_tb import stopwatch_pkg::*; ();

  localparam int TICK         = 600;       // cycles per centisecond
  localparam int WORD_TIMEOUT = 3 * TICK;  // longest wait for one word
  localparam int SEED         = 98665;

  logic         i_Clk = 1'b0;
  logic         res;
  logic         i_start_stop;
  logic         i_lap;
  logic         i_clear;
  spi_pins_t    spi;
  logic         running;
  logic         showing;

  // spi decoder state
  display_word_t word_q [$];            // completed words, oldest first
  int            cs_count  = 0;         // chip select pulses seen
  logic [15:0]   shift_in  = '0;
  int            bit_count = 0;
  logic          prev_sclk = 1'b0;
  logic          prev_cs_n = 1'b1;

  // frame assembly and bookkeeping
  int            asm_idx = 0;           // next digit expected
  logic [3:0]    asm_digits [DIGIT_COUNT];
  time_digits_t  last_frame = '0;       // newest complete frame
  int            errors = 0;
  int            test_errors = 0;
  int            tests_run = 0;
  int            tests_failed = 0;
  string         cur_test = "none";
  bit            wait_failed = 1'b0;    // a word wait ran out

  stopwatch_top #(.CLKS_PER_TICK(TICK)) UUT (
    .i_Clk        (i_Clk),
    .res          (res),
    .i_start_stop (i_start_stop),
    .i_lap        (i_lap),
    .i_clear      (i_clear),
    .o_spi        (spi),
    .o_running    (running),
    .o_showing    (showing)
  );

  always #20 i_Clk = ~i_Clk;  // 40 ns period

  //////////////////////////////////////////////////
  // error reporting
  task automatic report_error(input string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
    test_errors++;
  endtask

  task automatic report_value(input string what, input string exp, input string act);
    $display("FAIL %s: %s expected %s actual %s", cur_test, what, exp, act);
    errors++;
    test_errors++;
  endtask

  function automatic int to_centis(input time_digits_t t);
    int mins;
    int secs;
    mins = int'(t.min_tens) * 10 + int'(t.min_ones);
    secs = mins * 60 + int'(t.sec_tens) * 10 + int'(t.sec_ones);
    return secs * 100 + int'(t.ces_tens) * 10 + int'(t.ces_ones);
  endfunction

  function automatic time_digits_t from_centis(input int c);
    time_digits_t t;
    int v;
    v = c % 360000;  // 60:00.00 wraps
    t.ces_ones = DIGIT_W'(v % 10);
    t.ces_tens = DIGIT_W'((v / 10) % 10);
    t.sec_ones = DIGIT_W'((v / 100) % 10);
    t.sec_tens = TENS_W'((v / 1000) % 6);
    t.min_ones = DIGIT_W'((v / 6000) % 10);
    t.min_tens = TENS_W'(v / 60000);
    return t;
  endfunction

  function automatic string time_text(input time_digits_t t);
    return $sformatf("%0d%0d:%0d%0d.%0d%0d", t.min_tens, t.min_ones,
                     t.sec_tens, t.sec_ones, t.ces_tens, t.ces_ones);
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  task automatic check_word(input display_word_t exp, input display_word_t act);
    if (exp !== act) begin
      report_value("word", $sformatf("%h", exp), $sformatf("%h", act));
    end
  endtask

  task automatic check_time(input time_digits_t exp, input time_digits_t act);
    if (exp !== act) begin
      report_value("time", time_text(exp), time_text(act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      report_value(name, $sformatf("%b", exp), $sformatf("%b", act));
    end
  endtask

  //////////////////////////////////////////////////
  // spi decoder, samples between clock edges
  always @(negedge i_Clk) begin
    if (res) begin
      if (prev_cs_n && !spi.cs_n) begin
        cs_count++;  // new word starts
        bit_count = 0;
      end
      if (!spi.cs_n && spi.sclk && !prev_sclk) begin
        shift_in = {shift_in[14:0], spi.mosi};  // rising sclk, msb first
        bit_count++;
      end
      if (!prev_cs_n && spi.cs_n) begin
        if (bit_count == WORD_W) begin
          word_q.push_back(display_word_t'(shift_in));
        end else begin
          report_error($sformatf("chip select pulse carried %0d bits", bit_count));
        end
      end
      prev_sclk = spi.sclk;
      prev_cs_n = spi.cs_n;
    end
  end

  // digit words in address order build a frame
  task automatic accept_word(input display_word_t w, output bit done);
    int k;
    int lim;
    done = 1'b0;
    k = int'(w.addr) - int'(ADDR_DIGIT_BASE);
    if (k == 0) begin
      asm_idx = 0;  // frame start resyncs
    end
    if (k < 0 || k >= DIGIT_COUNT) begin
      asm_idx = 0;  // setup word
    end else if (k != asm_idx) begin
      if (asm_idx != 0) begin
        report_value("digit address", $sformatf("%0d", int'(ADDR_DIGIT_BASE) + asm_idx),
                     $sformatf("%0d", w.addr));
      end
      asm_idx = 0;  // tail of a frame cut by a drain
    end else begin
      lim = (k == 3 || k == 5) ? SEX_MOD : DEC_MOD;
      if (int'(w.data) >= lim) begin
        report_value($sformatf("digit %0d", k), $sformatf("below %0d", lim),
                     $sformatf("%0d", w.data));
      end
      asm_digits[k] = w.data[DIGIT_W-1:0];
      asm_idx++;
      if (asm_idx == DIGIT_COUNT) begin
        last_frame = '{ces_ones: asm_digits[0], ces_tens: asm_digits[1],
                       sec_ones: asm_digits[2], sec_tens: asm_digits[3][TENS_W-1:0],
                       min_ones: asm_digits[4], min_tens: asm_digits[5][TENS_W-1:0]};
        done    = 1'b1;
        asm_idx = 0;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus and waits
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge i_Clk);
  endtask

  task automatic press_button(input int which);
    @(negedge i_Clk);
    case (which)
      0:       i_start_stop = 1'b1;
      1:       i_lap        = 1'b1;
      default: i_clear      = 1'b1;
    endcase
    wait_cycles(4);  // held 4 cycles
    i_start_stop = 1'b0;
    i_lap        = 1'b0;
    i_clear      = 1'b0;
  endtask

  task automatic wait_status(input int which, input logic value);
    int n;
    n = 0;
    while (((which == 0) ? running : showing) !== value && n < 20) begin
      @(negedge i_Clk);
      n++;
    end
    if (((which == 0) ? running : showing) !== value) begin
      report_error($sformatf("%s did not become %b within 20 cycles",
                             (which == 0) ? "running" : "showing", value));
    end
  endtask

  task automatic get_word(output display_word_t w);
    int n;
    n = 0;
    w = '0;
    while (word_q.size() == 0 && n < WORD_TIMEOUT) begin
      @(negedge i_Clk);
      n++;
    end
    if (word_q.size() == 0) begin
      report_error($sformatf("no SPI word arrived within %0d cycles", n));
      wait_failed = 1'b1;
    end else begin
      w = word_q.pop_front();
    end
  endtask

  task automatic get_frame(output time_digits_t t);
    display_word_t w;
    bit            done;
    int            words;
    done  = 1'b0;
    words = 0;
    // a partial frame plus a full one at most
    while (!done && !wait_failed && words < 2 * DIGIT_COUNT + 1) begin
      get_word(w);
      words++;
      if (!wait_failed) begin
        accept_word(w, done);
      end
    end
    if (!done && !wait_failed) begin
      report_error($sformatf("no complete frame within %0d words", words));
      wait_failed = 1'b1;
    end
    t = last_frame;
  endtask

  task automatic drain_frames();
    bit done;
    while (word_q.size() > 0) begin
      accept_word(word_q.pop_front(), done);  // keeps last_frame current
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
    wait_failed = 1'b0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %-12s ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", cur_test, test_errors);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  task automatic test_reset_state();
    display_word_t w;
    bit            done;
    int            pulses;
    begin_test("reset_state");
    check_bit("running", 1'b0, running);
    check_bit("showing", 1'b1, showing);
    check_bit("cs_n", 1'b1, spi.cs_n);
    pulses = cs_count;
    wait_cycles(2000);  // no ticks while stopped
    if (cs_count != pulses) begin
      report_error("SPI activity while the watch was stopped");
    end
    press_button(0);
    get_word(w);
    check_word('{addr: ADDR_DECODE_MODE, data: DECODE_ALL_BCD}, w);
    for (int k = 0; k < DIGIT_COUNT && !wait_failed; k++) begin
      get_word(w);
      check_word('{addr: ADDR_DIGIT_BASE + 8'(k), data: 8'h00}, w);
      accept_word(w, done);
    end
    end_test();
  endtask

  task automatic test_counting();
    time_digits_t first;
    time_digits_t prev;
    time_digits_t cur;
    int           n;
    begin_test("counting");
    n = 3 + int'($urandom % 6);  // random run length in ticks
    drain_frames();
    get_frame(first);
    prev = first;
    cur  = first;
    for (int i = 0; i < n && !wait_failed; i++) begin
      get_frame(cur);
      // one tick between frames, so each one is later
      if (to_centis(cur) <= to_centis(prev)) begin
        report_value("rising time", $sformatf("after %s", time_text(prev)), time_text(cur));
      end
      prev = cur;
    end
    if (to_centis(cur) - to_centis(first) > n) begin
      report_value("advance", $sformatf("at most %0d", n),
                   $sformatf("%0d", to_centis(cur) - to_centis(first)));
    end
    end_test();
  endtask

  task automatic test_stop();
    time_digits_t held;
    time_digits_t cur;
    int           pulses;
    begin_test("stop");
    press_button(0);
    wait_status(0, 1'b0);
    check_bit("running", 1'b0, running);
    wait_cycles(1000);  // frame in flight completes
    drain_frames();
    held   = last_frame;
    pulses = cs_count;
    wait_cycles(3 * TICK);
    if (cs_count != pulses) begin
      report_error("frames kept arriving after stop");
    end
    // frozen time shows up one tick later than the last frame
    press_button(0);
    wait_status(0, 1'b1);
    get_frame(cur);
    check_time(from_centis(to_centis(held) + 1), cur);
    end_test();
  endtask

  task automatic test_lap();
    time_digits_t held;
    time_digits_t cur;
    int           pulses;
    begin_test("lap");
    press_button(1);
    wait_status(1, 1'b0);
    wait_cycles(1000);
    drain_frames();
    held   = last_frame;
    pulses = cs_count;
    wait_cycles(5 * TICK);  // display frozen, count running
    if (cs_count != pulses) begin
      report_error("chip select pulsed while the display was frozen");
    end
    check_bit("running", 1'b1, running);
    press_button(1);
    wait_status(1, 1'b1);
    get_frame(cur);
    // five frozen tick periods still counted
    if (to_centis(cur) < to_centis(held) + 5) begin
      report_value("resumed time", $sformatf("5 or more after %s", time_text(held)),
                   time_text(cur));
    end
    end_test();
  endtask

  task automatic test_clear();
    time_digits_t cur;
    begin_test("clear");
    press_button(0);
    wait_status(0, 1'b0);
    wait_cycles(1000);
    drain_frames();
    press_button(2);
    press_button(0);
    wait_status(0, 1'b1);
    get_frame(cur);
    if (to_centis(cur) > 1) begin
      report_value("restart time", "00:00.01 or less", time_text(cur));  // one tick allowed
    end
    end_test();
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial begin
    res          = 1'b0;
    i_start_stop = 1'b0;
    i_lap        = 1'b0;
    i_clear      = 1'b0;
    void'($urandom(SEED));
    repeat (3) @(negedge i_Clk);
    res = 1'b1;
    @(negedge i_Clk);
    test_reset_state();
    test_counting();
    test_stop();
    test_lap();
    test_clear();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog for the whole run
  initial begin
    #(64'd200000 * 40);
    $display("simulation ran past 200000 cycles");
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/stopwatch_top.sv
`default_nettype none
`timescale 1ns/1ps

module stopwatch_top import stopwatch_pkg::*; #(
  parameter int CLKS_PER_TICK = 10000
) (
  input  wire            i_Clk,
  input  wire            res,
  input  wire            i_start_stop,
  input  wire            i_lap,
  input  wire            i_clear,
  output wire spi_pins_t o_spi,
  output wire            o_running,
  output wire            o_showing
);

  logic          tick;        // one centisecond
  time_digits_t  cur_time;
  display_word_t word;        // sequencer to shifter
  logic          word_valid;
  logic          tx_ready;

  run_control u_run_control (
    .i_Clk        (i_Clk),
    .res          (res),
    .i_start_stop (i_start_stop),
    .i_lap        (i_lap),
    .o_running    (o_running),
    .o_showing    (o_showing)
  );

  tick_divider #(.CLKS_PER_TICK(CLKS_PER_TICK)) u_tick_divider (
    .i_Clk     (i_Clk),
    .res       (res),
    .i_running (o_running),
    .i_clear   (i_clear),
    .o_tick    (tick)
  );

  bcd_time_counter u_time_counter (
    .i_Clk   (i_Clk),
    .res     (res),
    .i_tick  (tick),
    .i_clear (i_clear),
    .o_time  (cur_time)
  );

  display_sequencer u_display_sequencer (
    .i_Clk        (i_Clk),
    .res          (res),
    .i_tick       (tick),
    .i_showing    (o_showing),
    .i_time       (cur_time),
    .i_ready      (tx_ready),
    .o_word       (word),
    .o_word_valid (word_valid)
  );

  spi_word_tx u_spi_word_tx (
    .i_Clk        (i_Clk),
    .res          (res),
    .i_word       (word),
    .i_word_valid (word_valid),
    .o_ready      (tx_ready),
    .o_spi        (o_spi)
  );

endmodule

`default_nettype wire

//--- hdl/spi_word_tx.sv
`default_nettype none
`timescale 1ns/1ps

module spi_word_tx import stopwatch_pkg::*; (
  input  wire                i_Clk,
  input  wire                res,
  input  wire display_word_t i_word,
  input  wire                i_word_valid,
  output logic               o_ready,
  output spi_pins_t          o_spi
);

  typedef enum logic [1:0] {
    TX_IDLE,   // ready for a word
    TX_SHIFT,  // cs_n low, bits on the wire
    TX_GAP     // cs_n high recovery
  } tx_state_t;

  tx_state_t                              state;
  logic [WORD_W-1:0]                      shreg;     // msb drives mosi
  logic [$clog2(2*CLKS_PER_HALF_BIT)-1:0] half_cnt;  // position inside a bit
  logic [$clog2(WORD_W)-1:0]              bit_cnt;   // bits finished
  logic [$clog2(CS_GAP_CLKS+1)-1:0]       gap_cnt;
  logic                                   sclk;
  logic                                   cs_n;
  logic                                   bit_end;   // falling sclk edge

  assign o_ready = (state == TX_IDLE);
  assign bit_end = (half_cnt == 2 * CLKS_PER_HALF_BIT - 1);
  assign o_spi   = '{sclk: sclk, mosi: shreg[WORD_W-1], cs_n: cs_n};

  //////////////////////////////////////////////////
  // shifter, mode 0
  always_ff @(posedge i_Clk or negedge res) begin
    if (!res) begin
      state    <= TX_IDLE;
      shreg    <= '0;  // mosi idles low
      half_cnt <= '0;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
      sclk     <= 1'b0;  // cpol 0
      cs_n     <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          if (i_word_valid) begin
            shreg    <= i_word;  // msb valid before first rising edge
            cs_n     <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            state    <= TX_SHIFT;
          end
        end
        TX_SHIFT: begin
          half_cnt <= bit_end ? '0 : half_cnt + 1'b1;
          if (half_cnt == CLKS_PER_HALF_BIT - 1) begin
            sclk <= 1'b1;  // slave samples here
          end
          if (bit_end) begin
            sclk    <= 1'b0;
            shreg   <= shreg << 1;  // next bit on the falling edge
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == WORD_W - 1) begin
              cs_n    <= 1'b1;  // word complete
              gap_cnt <= '0;
              state   <= TX_GAP;
            end
          end
        end
        TX_GAP: begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == CS_GAP_CLKS - 1) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // no clock edges outside a cs pulse
  a_sclk_idle: assert property (@(posedge i_Clk) disable iff (!res)
    cs_n |-> !sclk);

endmodule

`default_nettype wire

//--- hdl/display_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module display_sequencer import stopwatch_pkg::*; (
  input  wire               i_Clk,
  input  wire               res,
  input  wire               i_tick,
  input  wire               i_showing,
  input  wire time_digits_t i_time,
  input  wire               i_ready,
  output display_word_t     o_word,
  output logic              o_word_valid
);

  typedef enum logic [1:0] {
    SETUP,  // decode mode word, once
    IDLE,   // waiting for a tick
    SEND    // digit words of one frame
  } seq_state_t;

  seq_state_t                     state;
  time_digits_t                   frame;      // time captured at the tick
  logic [$clog2(DIGIT_COUNT)-1:0] digit_idx;  // digit in flight
  logic [DIGIT_W-1:0]             digit_val;
  logic                           accepted;   // handshake completes
  logic                           capture;    // new frame starts

  assign accepted = o_word_valid & i_ready;
  assign capture  = i_tick & i_showing &
                    ((state == IDLE) | ((state == SETUP) & ~o_word_valid));

  // digit k maps to driver address base + k
  always_comb begin
    case (digit_idx)
      0:       digit_val = frame.ces_ones;
      1:       digit_val = frame.ces_tens;
      2:       digit_val = frame.sec_ones;
      3:       digit_val = DIGIT_W'(frame.sec_tens);
      4:       digit_val = frame.min_ones;
      default: digit_val = DIGIT_W'(frame.min_tens);
    endcase
  end

  //////////////////////////////////////////////////
  // control
  always_ff @(posedge i_Clk or negedge res) begin
    if (!res) begin
      state        <= SETUP;
      digit_idx    <= '0;
      o_word_valid <= 1'b0;
    end else begin
      case (state)
        SETUP: begin
          if (accepted) begin
            o_word_valid <= 1'b0;
            digit_idx    <= '0;
            state        <= SEND;  // first frame straight after setup
          end else if (capture) begin
            o_word_valid <= 1'b1;  // setup goes out with the first tick
          end
        end
        IDLE: begin
          if (capture) begin
            digit_idx <= '0;
            state     <= SEND;
          end
        end
        SEND: begin
          if (accepted) begin
            o_word_valid <= 1'b0;
            if (digit_idx == DIGIT_COUNT - 1) begin
              state <= IDLE;  // frame done, later ticks start the next one
            end else begin
              digit_idx <= digit_idx + 1'b1;
            end
          end else if (!o_word_valid) begin
            o_word_valid <= 1'b1;
          end
        end
        default: state <= SETUP;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // payload
  always_ff @(posedge i_Clk) begin
    if (capture) begin
      frame <= i_time;  // ticks during a frame are skipped
    end
    if (state == SETUP) begin
      o_word <= '{addr: ADDR_DECODE_MODE, data: DECODE_ALL_BCD};
    end else if (state == SEND && !o_word_valid) begin
      o_word <= '{addr: ADDR_DIGIT_BASE + 8'(digit_idx), data: 8'(digit_val)};
    end
  end

  // word held until the transmitter takes it
  a_word_stable: assert property (@(posedge i_Clk) disable iff (!res)
    o_word_valid && !i_ready |=> o_word_valid && $stable(o_word));

endmodule

`default_nettype wire

//--- hdl/bcd_time_counter.sv
`default_nettype none
`timescale 1ns/1ps

module bcd_time_counter import stopwatch_pkg::*; (
  input  wire          i_Clk,
  input  wire          res,
  input  wire          i_tick,
  input  wire          i_clear,
  output time_digits_t o_time
);

  logic [DIGIT_W-1:0]     dig [DIGIT_COUNT];  // lsd first
  logic [DIGIT_COUNT-1:0] at_max;             // digit sits on its top value
  logic [DIGIT_COUNT-1:0] step;               // carry enable per digit

  // tens of seconds and minutes roll at 6
  function automatic logic [DIGIT_W-1:0] digit_top(input int k);
    if (k == 3 || k == 5) begin
      digit_top = DIGIT_W'(SEX_MOD - 1);
    end else begin
      digit_top = DIGIT_W'(DEC_MOD - 1);
    end
  endfunction

  always_comb begin
    for (int k = 0; k < DIGIT_COUNT; k++) begin
      at_max[k] = (dig[k] == digit_top(k));
    end
    step[0] = i_tick;
    for (int k = 1; k < DIGIT_COUNT; k++) begin
      step[k] = step[k-1] & at_max[k-1];  // all lower digits at max
    end
  end

  always_ff @(posedge i_Clk or negedge res) begin
    if (!res) begin
      for (int k = 0; k < DIGIT_COUNT; k++) begin
        dig[k] <= '0;
      end
    end else if (i_clear) begin
      for (int k = 0; k < DIGIT_COUNT; k++) begin
        dig[k] <= '0;  // clear wins over a tick
      end
    end else begin
      for (int k = 0; k < DIGIT_COUNT; k++) begin
        if (step[k]) begin
          dig[k] <= at_max[k] ? '0 : dig[k] + 1'b1;  // 59:59.99 wraps to zero
        end
      end
    end
  end

  assign o_time.ces_ones = dig[0];
  assign o_time.ces_tens = dig[1];
  assign o_time.sec_ones = dig[2];
  assign o_time.sec_tens = dig[3][TENS_W-1:0];  // upper bit always 0
  assign o_time.min_ones = dig[4];
  assign o_time.min_tens = dig[5][TENS_W-1:0];

  // range check also covers the narrowed tens fields
  for (genvar g = 0; g < DIGIT_COUNT; g++) begin : g_range
    a_digit_range: assert property (@(posedge i_Clk) disable iff (!res)
      dig[g] <= digit_top(g));
  end

endmodule

`default_nettype wire

//--- hdl/run_control.sv
`default_nettype none
`timescale 1ns/1ps

module run_control (
  input  wire  i_Clk,
  input  wire  res,
  input  wire  i_start_stop,
  input  wire  i_lap,
  output logic o_running,
  output logic o_showing
);

  // bit 0 start/stop, bit 1 lap
  logic [1:0] btn_meta;  // first sync stage
  logic [1:0] btn_sync;  // second sync stage
  logic [1:0] btn_prev;  // edge register
  logic [1:0] btn_edge;  // rising edge seen

  assign btn_edge = btn_sync & ~btn_prev;

  always_ff @(posedge i_Clk or negedge res) begin
    if (!res) begin
      btn_meta  <= '0;
      btn_sync  <= '0;
      btn_prev  <= '0;
      o_running <= 1'b0;  // stopped
      o_showing <= 1'b1;  // display live
    end else begin
      btn_meta <= {i_lap, i_start_stop};
      btn_sync <= btn_meta;
      btn_prev <= btn_sync;
      if (btn_edge[0]) begin
        o_running <= ~o_running;  // start / stop toggle
      end
      if (btn_edge[1]) begin
        o_showing <= ~o_showing;  // lap freezes the display
      end
    end
  end

  // toggles only follow a detected edge
  a_run_on_edge: assert property (@(posedge i_Clk) disable iff (!res)
    $changed(o_running) |-> $past(btn_edge[0]));
  a_show_on_edge: assert property (@(posedge i_Clk) disable iff (!res)
    $changed(o_showing) |-> $past(btn_edge[1]));

endmodule

`default_nettype wire

//--- hdl/tick_divider.sv
`default_nettype none
`timescale 1ns/1ps

module tick_divider #(
  parameter int CLKS_PER_TICK = 10000
) (
  input  wire  i_Clk,
  input  wire  res,
  input  wire  i_running,
  input  wire  i_clear,
  output logic o_tick
);

  logic [$clog2(CLKS_PER_TICK)-1:0] cnt;  // cycles into this centisecond
  logic                             wrap;  // last cycle of the period

  assign wrap = (cnt == CLKS_PER_TICK - 1);

  always_ff @(posedge i_Clk or negedge res) begin
    if (!res) begin
      cnt    <= '0;
      o_tick <= 1'b0;
    end else if (i_clear) begin
      cnt    <= '0;  // fresh centisecond after clear
      o_tick <= 1'b0;
    end else begin
      o_tick <= i_running & wrap;
      if (i_running) begin
        cnt <= wrap ? '0 : cnt + 1'b1;  // holds while stopped, keeps the fraction
      end
    end
  end

  // stopped watch produces no ticks
  a_no_tick_stopped: assert property (@(posedge i_Clk) disable iff (!res)
    (!i_running) [*2] |-> !o_tick);

endmodule

`default_nettype wire

//--- hdl/stopwatch_pkg.sv
`default_nettype none

package stopwatch_pkg;

  //////////////////////////////////////////////////
  // time digits
  localparam int DIGIT_W     = 4;   // one bcd digit
  localparam int TENS_W      = 3;   // tens of sec / min, 0..5
  localparam int DEC_MOD     = 10;  // decimal digit
  localparam int SEX_MOD     = 6;   // sexagesimal tens digit
  localparam int DIGIT_COUNT = 6;   // words per display frame

  //////////////////////////////////////////////////
  // spi link, mode 0
  localparam int CLKS_PER_HALF_BIT = 2;   // sclk = i_Clk / 4
  localparam int CS_GAP_CLKS       = 2;   // cs_n high between words
  localparam int WORD_W            = 16;  // one word per cs pulse

  //////////////////////////////////////////////////
  // display driver registers
  localparam logic [7:0] ADDR_DECODE_MODE = 8'h09;  // decode mode register
  localparam logic [7:0] DECODE_ALL_BCD   = 8'hFF;  // code b on every digit
  localparam logic [7:0] ADDR_DIGIT_BASE  = 8'h01;  // digit k at base + k

  // current time, lsd first
  typedef struct packed {
    logic [DIGIT_W-1:0] ces_ones;
    logic [DIGIT_W-1:0] ces_tens;
    logic [DIGIT_W-1:0] sec_ones;
    logic [TENS_W-1:0]  sec_tens;
    logic [DIGIT_W-1:0] min_ones;
    logic [TENS_W-1:0]  min_tens;
  } time_digits_t;

  // address byte goes out first
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } display_word_t;

  typedef struct packed {
    logic sclk;
    logic mosi;
    logic cs_n;  // active low
  } spi_pins_t;

endpackage

`default_nettype wire
